/* rp_pkg.sv */
// shared sample, bus and register map types and constants
package rp_pkg;

  //////////////////////
  // analog path
  //////////////////////

  localparam int unsigned N_CH = 2;        // ADC / DAC channel pairs

  typedef logic        [16-1:0] adc_raw_t;  // raw ADC word, two reserved LSBs
  typedef logic signed [14-1:0] sample_t;   // two's complement sample
  typedef logic signed [15-1:0] sum_t;      // gen + ctl, one guard bit
  typedef logic        [14-1:0] dac_code_t; // unsigned neg-slope DAC code

  //////////////////////
  // system bus
  //////////////////////

  typedef logic [32-1:0] sys_addr_t;
  typedef logic [32-1:0] sys_data_t;
  typedef logic [ 3-1:0] region_t;          // addr[22:20], 1 MiB regions
  typedef logic [20-1:0] sys_ofs_t;         // offset inside a region

  typedef logic [ 8-1:0] pdm_level_t;

  // housekeeping map
  localparam sys_data_t HK_ID       = 32'h5250_0001;
  localparam sys_ofs_t  REG_HK_ID   = 20'h00;
  localparam sys_ofs_t  REG_HK_LOOP = 20'h04;
  localparam sys_ofs_t  REG_HK_LED  = 20'h30;

  // pdm map, channel k at base + 4*k
  localparam sys_ofs_t  REG_PDM_BASE = 20'h20;

endpackage : rp_pkg

/* sys_bus_if.sv */
// system bus interface, master and slave modports
`timescale 1ns/1ps

interface sys_bus_if;
  import rp_pkg::*;

  sys_addr_t addr;   // request address
  sys_data_t wdata;  // write data
  logic      wen;    // one-cycle write strobe
  logic      ren;    // one-cycle read strobe
  sys_data_t rdata;  // valid with ack
  logic      err;    // unmapped access
  logic      ack;    // one cycle after strobe

  modport master (output addr, wdata, wen, ren, input  rdata, err, ack);
  modport slave  (input  addr, wdata, wen, ren, output rdata, err, ack);

endinterface : sys_bus_if

/* sys_bus_decoder.sv */
// bus region decoder: strobe gating, response mux and error answer
`timescale 1ns/1ps

module sys_bus_decoder #(
  parameter rp_pkg::region_t HK_REGION  = 3'd0,  // housekeeping
  parameter rp_pkg::region_t PDM_REGION = 3'd4   // pdm outputs
)(
  input  logic              adc_clk,
  input  logic              rst_i,
  input  rp_pkg::sys_addr_t sys_addr_i,
  input  rp_pkg::sys_data_t sys_wdata_i,
  input  logic              sys_wen_i,
  input  logic              sys_ren_i,
  output rp_pkg::sys_data_t sys_rdata_o,
  output logic              sys_err_o,
  output logic              sys_ack_o,
  sys_bus_if.master         hk_bus,
  sys_bus_if.master         pdm_bus
);
  import rp_pkg::*;

  region_t region;     // region of the current request
  region_t region_q;   // region of last cycle's request
  logic    hk_sel, pdm_sel;
  logic    err_ack_q;  // answer for unmapped regions

  assign region  = sys_addr_i[22:20];
  assign hk_sel  = (region == HK_REGION);
  assign pdm_sel = (region == PDM_REGION);

  ////////////////////
  // request side
  ////////////////////

  // addr and data go everywhere, strobes only to the addressed slave
  assign hk_bus.addr   = sys_addr_i;
  assign hk_bus.wdata  = sys_wdata_i;
  assign hk_bus.wen    = sys_wen_i & hk_sel;
  assign hk_bus.ren    = sys_ren_i & hk_sel;
  assign pdm_bus.addr  = sys_addr_i;
  assign pdm_bus.wdata = sys_wdata_i;
  assign pdm_bus.wen   = sys_wen_i & pdm_sel;
  assign pdm_bus.ren   = sys_ren_i & pdm_sel;

  always_ff @(posedge adc_clk)
  begin
    if (rst_i)
    begin
      region_q  <= '0;
      err_ack_q <= 1'b0;
    end
    else
    begin
      if (sys_wen_i | sys_ren_i)
        region_q <= region;  // held until the next request
      err_ack_q <= (sys_wen_i | sys_ren_i) & ~hk_sel & ~pdm_sel;
    end
  end

  ////////////////////
  // response side
  ////////////////////

  always_comb
  begin
    if (region_q == HK_REGION)
    begin
      sys_rdata_o = hk_bus.rdata;
      sys_err_o   = hk_bus.err;
      sys_ack_o   = hk_bus.ack;
    end
    else if (region_q == PDM_REGION)
    begin
      sys_rdata_o = pdm_bus.rdata;
      sys_err_o   = pdm_bus.err;
      sys_ack_o   = pdm_bus.ack;
    end
    else
    begin
      sys_rdata_o = '0;         // unmapped reads zero
      sys_err_o   = err_ack_q;
      sys_ack_o   = err_ack_q;
    end
  end

  // master never strobes both at once
  a_one_strobe: assert property (@(posedge adc_clk) disable iff (rst_i)
    !(sys_wen_i && sys_ren_i));

  // whichever slave answers, ack follows a request by exactly one cycle
  a_ack_after_req: assert property (@(posedge adc_clk) disable iff (rst_i)
    sys_ack_o |-> $past(sys_wen_i || sys_ren_i));

endmodule : sys_bus_decoder

/* adc_frontend.sv */
// ADC input registers, neg-slope to two's complement, digital loop mux
`timescale 1ns/1ps

module adc_frontend (
  input  logic                                 adc_clk,
  input  logic                                 rst_i,
  input  rp_pkg::adc_raw_t [rp_pkg::N_CH-1:0] adc_dat_i,       // raw ADC words
  input  rp_pkg::sample_t  [rp_pkg::N_CH-1:0] sat_dat_i,       // saturated DAC values
  input  logic                                 digital_loop_i,
  output rp_pkg::sample_t  [rp_pkg::N_CH-1:0] adc_dat_o
);
  import rp_pkg::*;

  // raw code that converts to a zero sample
  localparam logic [14-1:0] RAW_ZERO = 14'h1fff;

  logic [N_CH-1:0] [14-1:0] adc_raw_q;

  for (genvar ch = 0; ch < N_CH; ch++)
  begin : g_ch
    // input register, lowest 2 bits reserved on the 16-bit ADC
    always_ff @(posedge adc_clk)
    begin
      if (rst_i)
        adc_raw_q[ch] <= RAW_ZERO;
      else
        adc_raw_q[ch] <= adc_dat_i[ch][16-1:2];
    end

    // neg-slope: keep msb, invert the rest
    assign adc_dat_o[ch] = digital_loop_i ? sat_dat_i[ch]
                                          : {adc_raw_q[ch][13], ~adc_raw_q[ch][12:0]};
  end

endmodule : adc_frontend

/* dac_backend.sv */
// DAC sum of generator and controller, saturation, code conversion, output regs
`timescale 1ns/1ps

module dac_backend (
  input  logic                                  adc_clk,
  input  logic                                  rst_i,
  input  rp_pkg::sample_t   [rp_pkg::N_CH-1:0] gen_dat_i,  // generator samples
  input  rp_pkg::sample_t   [rp_pkg::N_CH-1:0] ctl_dat_i,  // controller samples
  output rp_pkg::sample_t   [rp_pkg::N_CH-1:0] sat_dat_o,  // combinational saturated sums
  output rp_pkg::dac_code_t [rp_pkg::N_CH-1:0] dac_dat_o,  // registered DAC codes
  output logic                                  dac_rst_o
);
  import rp_pkg::*;

  localparam dac_code_t DAC_ZERO = 14'h1fff;  // neg-slope code of 0

  sum_t [N_CH-1:0] sum;

  //////////////////////
  // sum and clamp
  //////////////////////

  for (genvar ch = 0; ch < N_CH; ch++)
  begin : g_ch
    sum_t sat_ext;  // saturated value at sum width

    // explicit sign extension to 15 bits
    assign sum[ch] = {gen_dat_i[ch][13], gen_dat_i[ch]}
                   + {ctl_dat_i[ch][13], ctl_dat_i[ch]};

    // clamp toward the sum's sign when the two top bits differ
    assign sat_dat_o[ch] = (sum[ch][14] ^ sum[ch][13])
                         ? {sum[ch][14], {13{~sum[ch][14]}}}
                         : sum[ch][13:0];

    assign sat_ext = {sat_dat_o[ch][13], sat_dat_o[ch]};

    // output register converts signed to neg-slope unsigned
    always_ff @(posedge adc_clk)
    begin
      if (rst_i)
        dac_dat_o[ch] <= DAC_ZERO;
      else
        dac_dat_o[ch] <= {sat_dat_o[ch][13], ~sat_dat_o[ch][12:0]};
    end

    // a clamp keeps the sign of the true sum and never grows its magnitude
    a_sat_sign: assert property (@(posedge adc_clk) disable iff (rst_i)
      sum[ch][14] ? (sat_ext[14] && sat_ext >= sum[ch])
                  : (!sat_ext[14] && sat_ext <= sum[ch]));
  end

  //////////////////////
  // DAC reset
  //////////////////////

  // stretched by one cycle past the system reset
  always_ff @(posedge adc_clk)
  begin
    dac_rst_o <= rst_i;
  end

endmodule : dac_backend

/* hk_regs.sv */
// housekeeping registers: ID, digital loop bit and LEDs
`timescale 1ns/1ps

module hk_regs (
  input  logic          adc_clk,
  input  logic          rst_i,
  sys_bus_if.slave      bus,
  output logic          digital_loop_o,  // ADC path replaced by DAC values
  output logic [8-1:0]  led_o
);
  import rp_pkg::*;

  sys_ofs_t  ofs;
  sys_data_t rd_val;

  assign ofs = bus.addr[19:0];

  ////////////////////
  // writes
  ////////////////////

  always_ff @(posedge adc_clk)
  begin
    if (rst_i)
    begin
      digital_loop_o <= 1'b0;
      led_o          <= '0;
    end
    else if (bus.wen)
    begin
      // ID is read only, unknown offsets dropped
      if (ofs == REG_HK_LOOP)
        digital_loop_o <= bus.wdata[0];
      if (ofs == REG_HK_LED)
        led_o <= bus.wdata[7:0];
    end
  end

  ////////////////////
  // reads
  ////////////////////

  always_comb
  begin
    case (ofs)
      REG_HK_ID:   rd_val = HK_ID;
      REG_HK_LOOP: rd_val = {31'h0, digital_loop_o};
      REG_HK_LED:  rd_val = {24'h0, led_o};
      default:     rd_val = '0;   // holes read zero
    endcase
  end

  always_ff @(posedge adc_clk)
  begin
    if (bus.ren)
      bus.rdata <= rd_val;  // only looked at with ack
  end

  always_ff @(posedge adc_clk)
  begin
    if (rst_i)
      bus.ack <= 1'b0;
    else
      bus.ack <= bus.wen | bus.ren;
  end

  assign bus.err = 1'b0;  // every offset is legal here

endmodule : hk_regs

/* pdm_gen.sv */
// PDM level registers and first-order sigma-delta modulators
`timescale 1ns/1ps

module pdm_gen #(
  parameter int unsigned N_PDM = 4  // number of outputs
)(
  input  logic             adc_clk,
  input  logic             rst_i,
  sys_bus_if.slave         bus,
  output logic [N_PDM-1:0] pdm_o
);
  import rp_pkg::*;

  pdm_level_t level_q [N_PDM];
  sys_ofs_t   ofs;
  sys_data_t  rd_val;

  assign ofs = bus.addr[19:0];

  ////////////////////
  // level registers
  ////////////////////

  always_ff @(posedge adc_clk)
  begin
    if (rst_i)
    begin
      for (int k = 0; k < N_PDM; k++)
        level_q[k] <= '0;
    end
    else if (bus.wen)
    begin
      for (int k = 0; k < N_PDM; k++)
        if (ofs == REG_PDM_BASE + sys_ofs_t'(4 * k))
          level_q[k] <= bus.wdata[7:0];
    end
  end

  always_comb
  begin
    rd_val = '0;  // no match reads zero
    for (int k = 0; k < N_PDM; k++)
      if (ofs == REG_PDM_BASE + sys_ofs_t'(4 * k))
        rd_val = {24'h0, level_q[k]};
  end

  always_ff @(posedge adc_clk)
  begin
    if (bus.ren)
      bus.rdata <= rd_val;
  end

  always_ff @(posedge adc_clk)
  begin
    if (rst_i)
      bus.ack <= 1'b0;
    else
      bus.ack <= bus.wen | bus.ren;
  end

  assign bus.err = 1'b0;

  ////////////////////
  // modulators
  ////////////////////

  for (genvar k = 0; k < N_PDM; k++)
  begin : g_mod
    logic [8-1:0] acc_q;    // phase accumulator
    logic [9-1:0] acc_nxt;  // msb is the carry
    logic         pdm_q;

    assign acc_nxt = {1'b0, acc_q} + {1'b0, level_q[k]};

    // carry rate = level/256, exact over any 256 cycles
    always_ff @(posedge adc_clk)
    begin
      if (rst_i)
      begin
        acc_q <= '0;
        pdm_q <= 1'b0;
      end
      else
      begin
        acc_q <= acc_nxt[7:0];
        pdm_q <= acc_nxt[8];
      end
    end

    assign pdm_o[k] = pdm_q;
  end

  // one request at a time means no back-to-back acks
  a_ack_single: assert property (@(posedge adc_clk) disable iff (rst_i)
    bus.ack |=> !bus.ack);

endmodule : pdm_gen

/* analog_top.sv */
// analog top: ADC front end, DAC back end, bus decoder, housekeeping and PDM
`timescale 1ns/1ps

module analog_top #(
  parameter rp_pkg::region_t HK_REGION  = 3'd0,
  parameter rp_pkg::region_t PDM_REGION = 3'd4,
  parameter int unsigned     N_PDM      = 4
)(
  input  logic                                  adc_clk,
  input  logic                                  rst_i,
  // ADC
  input  rp_pkg::adc_raw_t  [rp_pkg::N_CH-1:0] adc_dat_i,
  output rp_pkg::sample_t   [rp_pkg::N_CH-1:0] adc_dat_o,
  // generator and controller samples
  input  rp_pkg::sample_t   [rp_pkg::N_CH-1:0] gen_dat_i,
  input  rp_pkg::sample_t   [rp_pkg::N_CH-1:0] ctl_dat_i,
  // DAC
  output rp_pkg::dac_code_t [rp_pkg::N_CH-1:0] dac_dat_o,
  output logic                                  dac_rst_o,
  // slow outputs
  output logic [N_PDM-1:0]                      pdm_o,
  output logic [8-1:0]                          led_o,
  // system bus
  input  rp_pkg::sys_addr_t                     sys_addr_i,
  input  rp_pkg::sys_data_t                     sys_wdata_i,
  input  logic                                  sys_wen_i,
  input  logic                                  sys_ren_i,
  output rp_pkg::sys_data_t                     sys_rdata_o,
  output logic                                  sys_err_o,
  output logic                                  sys_ack_o
);
  import rp_pkg::*;

  sample_t [N_CH-1:0] sat_dat;       // saturated sums for the loop
  logic               digital_loop;

  sys_bus_if hk_bus  ();
  sys_bus_if pdm_bus ();

  ////////////////////
  // signal path
  ////////////////////

  adc_frontend i_adc (
    .adc_clk        (adc_clk     ),
    .rst_i          (rst_i       ),
    .adc_dat_i      (adc_dat_i   ),
    .sat_dat_i      (sat_dat     ),
    .digital_loop_i (digital_loop),
    .adc_dat_o      (adc_dat_o   )
  );

  dac_backend i_dac (
    .adc_clk   (adc_clk  ),
    .rst_i     (rst_i    ),
    .gen_dat_i (gen_dat_i),
    .ctl_dat_i (ctl_dat_i),
    .sat_dat_o (sat_dat  ),
    .dac_dat_o (dac_dat_o),
    .dac_rst_o (dac_rst_o)
  );

  ////////////////////
  // register bus
  ////////////////////

  sys_bus_decoder #(
    .HK_REGION  (HK_REGION ),
    .PDM_REGION (PDM_REGION)
  ) i_dec (
    .adc_clk     (adc_clk    ),
    .rst_i       (rst_i      ),
    .sys_addr_i  (sys_addr_i ),
    .sys_wdata_i (sys_wdata_i),
    .sys_wen_i   (sys_wen_i  ),
    .sys_ren_i   (sys_ren_i  ),
    .sys_rdata_o (sys_rdata_o),
    .sys_err_o   (sys_err_o  ),
    .sys_ack_o   (sys_ack_o  ),
    .hk_bus      (hk_bus     ),
    .pdm_bus     (pdm_bus    )
  );

  hk_regs i_hk (
    .adc_clk        (adc_clk     ),
    .rst_i          (rst_i       ),
    .bus            (hk_bus      ),
    .digital_loop_o (digital_loop),
    .led_o          (led_o       )
  );

  pdm_gen #(
    .N_PDM (N_PDM)
  ) i_pdm (
    .adc_clk (adc_clk),
    .rst_i   (rst_i  ),
    .bus     (pdm_bus),
    .pdm_o   (pdm_o  )
  );

endmodule : analog_top

/* tb_analog_top.sv */
// analog_top testbench with xorshift stimulus, reference model, compare tasks and timeout
`timescale 1ns/1ps

module tb_analog_top;
  import rp_pkg::*;

  localparam int MAX_CYCLES = 4000;  // well above the run length

  logic                 adc_clk;
  logic                 rst_i;
  adc_raw_t  [N_CH-1:0] adc_dat_i;
  sample_t   [N_CH-1:0] gen_dat_i;
  sample_t   [N_CH-1:0] ctl_dat_i;
  sample_t   [N_CH-1:0] adc_dat_o;
  dac_code_t [N_CH-1:0] dac_dat_o;
  logic                 dac_rst_o;
  logic [4-1:0]         pdm_o;
  logic [8-1:0]         led_o;
  sys_addr_t            sys_addr_i;
  sys_data_t            sys_wdata_i;
  logic                 sys_wen_i;
  logic                 sys_ren_i;
  sys_data_t            sys_rdata_o;
  logic                 sys_err_o;
  logic                 sys_ack_o;

  logic [31:0] rng = 32'h8062;  // xorshift state
  int          cycles = 0;
  int          errors = 0;
  int          tests = 0;
  int          failed_tests = 0;
  int          test_err0 = 0;      // error count at test start
  string       cur_test;

  analog_top UUT (.*);

  initial
  begin
    adc_clk = 1'b0;
    forever #5 adc_clk = ~adc_clk;
  end

  // hard limit on run time
  always @(posedge adc_clk)
  begin
    cycles++;
    if (cycles >= MAX_CYCLES)
    begin
      $display("timeout: run did not end within %0d cycles", MAX_CYCLES);
      $display("TEST FAILED");
      $finish;
    end
  end

  ////////////////////
  // model
  ////////////////////

  function automatic logic [31:0] next_rand();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  // reserved bits dropped and all but the sign flipped
  function automatic sample_t adc_model(adc_raw_t raw);
    return sample_t'(raw >> 2) ^ sample_t'(14'h1fff);
  endfunction

  function automatic sample_t sat_model(sample_t a, sample_t b);
    int s;
    s = int'(a) + int'(b);  // full precision sum
    if (s > 8191)
      s = 8191;
    else if (s < -8192)
      s = -8192;
    return sample_t'(s);
  endfunction

  function automatic dac_code_t code_model(sample_t s);
    return dac_code_t'(s) ^ 14'h1fff;
  endfunction

  function automatic sample_t extreme(logic [1:0] sel);
    case (sel)
      2'd0:    return 14'sh2000;  // most negative
      2'd1:    return 14'sh1fff;  // most positive
      2'd2:    return 14'sh0000;
      default: return 14'sh3fff;  // -1
    endcase
  endfunction

  function automatic sys_addr_t reg_addr(region_t rg, sys_ofs_t ofs);
    return {9'h0, rg, ofs};
  endfunction

  ////////////////////
  // compare tasks
  ////////////////////

  task automatic check_sample(string what, sample_t exp, sample_t act);
    if (act !== exp)
    begin
      $display("ERR %s %s: expected %0d, actual %0d", cur_test, what, exp, act);
      errors++;
    end
  endtask

  task automatic check_code(string what, dac_code_t exp, dac_code_t act);
    if (act !== exp)
    begin
      $display("ERR %s %s: expected %h, actual %h", cur_test, what, exp, act);
      errors++;
    end
  endtask

  task automatic check_data(string what, sys_data_t exp, sys_data_t act);
    if (act !== exp)
    begin
      $display("ERR %s %s: expected %h, actual %h", cur_test, what, exp, act);
      errors++;
    end
  endtask

  task automatic check_count(string what, int exp, int act);
    if (act != exp)
    begin
      $display("ERR %s %s: expected %0d, actual %0d", cur_test, what, exp, act);
      errors++;
    end
  endtask

  task automatic check_err(string what, bit exp, bit act);
    if (act != exp)
    begin
      $display("ERR %s %s: expected %b, actual %b", cur_test, what, exp, act);
      errors++;
    end
  endtask

  task automatic begin_test(string name);
    cur_test  = name;
    test_err0 = errors;
  endtask

  task automatic end_test();
    tests++;
    if (errors != test_err0)
      failed_tests++;
    $display("%s: %s, %0d errors", cur_test, (errors == test_err0) ? "pass" : "fail",
             errors - test_err0);
  endtask

  ////////////////////
  // stimulus
  ////////////////////

  // issue one request and sample the response at the negedge of the ack
  task automatic bus_access(input sys_addr_t addr, input sys_data_t wdata, input bit wr,
                            output sys_data_t rdata, output bit err);
    int waited;
    @(posedge adc_clk);
    sys_addr_i  <= addr;
    sys_wdata_i <= wdata;
    sys_wen_i   <= wr;
    sys_ren_i   <= ~wr;
    @(posedge adc_clk);
    sys_wen_i <= 1'b0;
    sys_ren_i <= 1'b0;
    @(negedge adc_clk);
    waited = 0;
    while (!sys_ack_o && waited < 8)
    begin
      @(negedge adc_clk);
      waited++;
    end
    if (!sys_ack_o)
    begin
      $display("%s: no ack for the access to address %h", cur_test, addr);
      errors++;
    end
    else if (waited != 0)
    begin
      $display("%s: ack for address %h came %0d cycles late", cur_test, addr, waited);
      errors++;
    end
    rdata = sys_rdata_o;
    err   = sys_err_o;
  endtask

  task automatic bus_write(input sys_addr_t addr, input sys_data_t data, output bit err);
    sys_data_t dummy;
    bus_access(addr, data, 1'b1, dummy, err);
  endtask

  task automatic bus_read(input sys_addr_t addr, output sys_data_t data, output bit err);
    bus_access(addr, '0, 1'b0, data, err);
  endtask

  // a new raw word every cycle, each checked one cycle later
  task automatic run_adc(int n);
    adc_raw_t [N_CH-1:0] raw;
    adc_raw_t [N_CH-1:0] prev;
    for (int i = 0; i <= n; i++)
    begin
      @(posedge adc_clk);
      prev = raw;
      if (i < n)
      begin
        for (int ch = 0; ch < N_CH; ch++)
          raw[ch] = adc_raw_t'(next_rand());
        adc_dat_i <= raw;
      end
      @(negedge adc_clk);  // prev has just passed the front end register
      if (i > 0)
        for (int ch = 0; ch < N_CH; ch++)
          check_sample("adc_dat_o", adc_model(prev[ch]), adc_dat_o[ch]);
    end
  endtask

  // every fourth pair from the extremes
  task automatic random_pair(input int i, output sample_t [N_CH-1:0] gv,
                             output sample_t [N_CH-1:0] cv);
    logic [31:0] r;
    for (int ch = 0; ch < N_CH; ch++)
    begin
      r = next_rand();
      if (i % 4 == 0)
      begin
        gv[ch] = extreme(r[1:0]);
        cv[ch] = extreme(r[3:2]);
      end
      else
      begin
        gv[ch] = sample_t'(r[13:0]);
        cv[ch] = sample_t'(r[29:16]);
      end
    end
  endtask

  ////////////////////
  // tests
  ////////////////////

  initial
  begin
    sample_t [N_CH-1:0] gv;
    sample_t [N_CH-1:0] cv;
    sample_t [N_CH-1:0] gp;
    sample_t [N_CH-1:0] cp;
    pdm_level_t         lvl [4];
    int                 cnt [4];
    sys_data_t          wd;
    sys_data_t          rd;
    bit                 err;
    sys_ofs_t           ofs;

    rst_i       = 1'b1;
    adc_dat_i   = '0;
    gen_dat_i   = '0;
    ctl_dat_i   = '0;
    sys_addr_i  = '0;
    sys_wdata_i = '0;
    sys_wen_i   = 1'b0;
    sys_ren_i   = 1'b0;

    // reset values and then the plain ADC path
    begin_test("reset_adc");
    repeat (2) @(posedge adc_clk);
    @(negedge adc_clk);
    check_err("dac_rst_o in reset", 1'b1, dac_rst_o);
    check_count("pdm_o in reset", 0, int'(pdm_o));
    check_data("led_o in reset", '0, sys_data_t'(led_o));
    repeat (2) @(posedge adc_clk);
    rst_i <= 1'b0;  // after 4 edges in reset
    @(negedge adc_clk);
    check_err("dac_rst_o after reset", 1'b1, dac_rst_o);
    for (int ch = 0; ch < N_CH; ch++)
      check_code("dac_dat_o after reset", code_model(14'sh0), dac_dat_o[ch]);
    @(posedge adc_clk);
    @(negedge adc_clk);
    check_err("dac_rst_o released", 1'b0, dac_rst_o);
    check_count("pdm_o after reset", 0, int'(pdm_o));
    check_data("led_o after reset", '0, sys_data_t'(led_o));
    run_adc(200);
    end_test();

    // sum, clamp and DAC code, one new pair per cycle
    begin_test("dac_path");
    for (int i = 0; i <= 200; i++)
    begin
      @(posedge adc_clk);
      gp = gv;
      cp = cv;
      if (i < 200)
      begin
        random_pair(i, gv, cv);
        gen_dat_i <= gv;
        ctl_dat_i <= cv;
      end
      @(negedge adc_clk);  // previous pair is in the output register
      if (i > 0)
        for (int ch = 0; ch < N_CH; ch++)
          check_code("dac_dat_o", code_model(sat_model(gp[ch], cp[ch])), dac_dat_o[ch]);
    end
    end_test();

    // digital loop on and then back off
    begin_test("loop");
    bus_write(reg_addr(3'd0, REG_HK_LOOP), 32'hffff_ffff, err);
    check_err("loop write err", 1'b0, err);
    bus_read(reg_addr(3'd0, REG_HK_LOOP), rd, err);
    check_data("loop reg", 32'h1, rd);  // only bit 0 kept
    @(posedge adc_clk);
    for (int i = 0; i < 50; i++)
    begin
      @(posedge adc_clk);
      random_pair(i, gv, cv);
      gen_dat_i <= gv;
      ctl_dat_i <= cv;
      @(negedge adc_clk);  // same cycle through the loop mux
      for (int ch = 0; ch < N_CH; ch++)
        check_sample("looped adc_dat_o", sat_model(gv[ch], cv[ch]), adc_dat_o[ch]);
    end
    bus_write(reg_addr(3'd0, REG_HK_LOOP), 32'h0, err);
    @(posedge adc_clk);
    run_adc(20);
    end_test();

    // housekeeping ID and LEDs
    begin_test("hk_regs");
    bus_write(reg_addr(3'd0, REG_HK_ID), next_rand(), err);  // read only
    bus_read(reg_addr(3'd0, REG_HK_ID), rd, err);
    check_data("id", HK_ID, rd);
    check_err("id err", 1'b0, err);
    for (int i = 0; i < 10; i++)
    begin
      wd = next_rand();
      bus_write(reg_addr(3'd0, REG_HK_LED), wd, err);
      bus_read(reg_addr(3'd0, REG_HK_LED), rd, err);
      check_data("led reg", {24'h0, wd[7:0]}, rd);
      check_data("led_o", {24'h0, wd[7:0]}, sys_data_t'(led_o));
    end
    end_test();

    // PDM levels and pulse density
    begin_test("pdm");
    for (int k = 0; k < 4; k++)
    begin
      wd     = next_rand();
      lvl[k] = (k == 0) ? 8'hff : wd[7:0];  // full scale on channel 0
      wd[7:0] = lvl[k];
      bus_write(reg_addr(3'd4, REG_PDM_BASE + sys_ofs_t'(4 * k)), wd, err);
      check_err("level write err", 1'b0, err);
    end
    for (int k = 0; k < 4; k++)
    begin
      bus_read(reg_addr(3'd4, REG_PDM_BASE + sys_ofs_t'(4 * k)), rd, err);
      check_data("level reg", {24'h0, lvl[k]}, rd);
    end
    repeat (2) @(posedge adc_clk);
    for (int k = 0; k < 4; k++)
      cnt[k] = 0;
    repeat (256)
    begin
      @(negedge adc_clk);
      for (int k = 0; k < 4; k++)
        if (pdm_o[k])
          cnt[k]++;
    end
    for (int k = 0; k < 4; k++)
      check_count("pdm_o ones in 256", int'(lvl[k]), cnt[k]);
    end_test();

    // unmapped regions answer with err
    begin_test("unmapped");
    for (int rg = 1; rg < 8; rg++)
    begin
      if (rg != 4)
      begin
        ofs = sys_ofs_t'(next_rand()) & 20'hffffc;
        bus_write(reg_addr(region_t'(rg), ofs), next_rand(), err);
        check_err("unmapped write err", 1'b1, err);
        bus_read(reg_addr(region_t'(rg), ofs), rd, err);
        check_err("unmapped read err", 1'b1, err);
        check_data("unmapped rdata", '0, rd);
      end
    end
    bus_read(reg_addr(3'd0, REG_HK_LED), rd, err);
    check_err("hk read err", 1'b0, err);
    bus_read(reg_addr(3'd4, REG_PDM_BASE), rd, err);
    check_err("pdm read err", 1'b0, err);
    bus_read(reg_addr(3'd4, 20'h100), rd, err);  // hole in mapped region
    check_err("pdm hole err", 1'b0, err);
    check_data("pdm hole rdata", '0, rd);
    end_test();

    $display("tests %0d, failed tests %0d, errors %0d", tests, failed_tests, errors);
    if (errors == 0)
      $display("TEST OK");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule : tb_analog_top

/* all.f */
rp_pkg.sv
sys_bus_if.sv
sys_bus_decoder.sv
adc_frontend.sv
dac_backend.sv
hk_regs.sv
pdm_gen.sv
analog_top.sv
tb_analog_top.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the analog_top testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_analog_top -f all.f \
  && ./obj_dir/Vtb_analog_top | tee /dev/stderr | grep -qx "TEST OK" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
